// ==== Makefile ====
# Verilator build and run of the CPU testbench

TOP = tb_cpu

.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cpu_cases.txt ====
// Each case gives its word count and store count, then the program words loaded at 0x100,
// then the expected store address and data pairs in order. A zero word count ends the list
// Register ALU operations with compares, inverses and shifts
1F 0E
80842101 80002502 00200312 68020003 00240321 68020403 00280312 68020803 002C0312 68020C03
00800312 68021003 00900312 68021403 00940312 68021803 00980312 68021C03 00A00312 68022003
00B00312 68022403 00B40312 68022803 00B80312 68022C03 00C00312 68023003 00C40312 68023403
20FFFF00
00000200 00000000 00000204 00000000 00000208 00000001 0000020C 00000001
00000210 FFFF8446 00000214 00000021 00000218 FFFF8425 0000021C FFFF8404
00000220 FFFF83FC 00000224 FFFFFFDE 00000228 00007BDA 0000022C 00007BFB
00000230 FFFFFC21 00000234 FFF08420
// Negative immediates in a dependent chain
0C 05
80FFF001 80000511 90FF0F12 98800123 9400F034 80FFFF45 68030001 68030402 68030803 68030C04
68031005 20FFFF00
00000300 FFFFFFF5 00000304 FFFFFF05 00000308 00007F04 0000030C 00007FF4
00000310 00007FF3
// Branches taken and not taken, then JAL with its link
16 03
80000501 80FFFD02 20000111 68040001 20000112 68040402 24000121 68040801 24000112 68040C01
28000111 68041002 28000112 2C000112 68041401 2C000111 30005404 68041801 68041C01 68042001
68042404 20FFFF00
00000404 FFFFFFFD 0000040C 00000005 00000424 00000144
// Store, load back, store again
09 04
80135701 68050001 48050002 68050402 80050003 48000035 68000835 68FFFC31 20FFFF00
00000500 00001357 00000504 00001357 00000508 00001357 000004FC 00001357
00

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // ********************
  // Widths and sizes
  // ********************

  // Datapath and instruction word
  localparam int DATA_W = 32;
  // Register number, sixteen registers
  localparam int REG_NO_W = 4;
  localparam int REG_WORDS = 1 << REG_NO_W;
  // Immediate field before extension
  localparam int IMM_W = 16;
  // Shift amount taken from rt
  localparam int SHAMT_W = 5;

  // Memory depths in words
  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 1024;
  // Word index bits within a byte address
  localparam int MEM_LSB = 2;
  localparam int IMEM_MSB = MEM_LSB + $clog2(IMEM_WORDS) - 1;
  localparam int DMEM_MSB = MEM_LSB + $clog2(DMEM_WORDS) - 1;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [REG_NO_W-1:0] reg_no_t;
  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;

  // First fetch address after start
  localparam word_t START_PC = 32'h100;
  // Byte step between instructions
  localparam word_t INST_BYTES = 32'd4;

  // ********************
  // Opcodes
  // ********************

  // Primary opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcode for ALUR, bits 25:18
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                prog_valid,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::word_t      prog_word,
  output logic                st_valid,
  output cpu_pkg::word_t      st_addr,
  output cpu_pkg::word_t      st_data,
  input  logic                st_ready
);
  import cpu_pkg::*;

  // Pipeline control
  logic hold;
  logic stall;
  logic redirect;
  word_t redirect_pc;

  // Fetch latch
  logic fe_valid;
  word_t fe_pc;
  word_t fe_inst;

  // Decode latch
  logic id_valid;
  op1_e id_op1;
  op2_e id_op2;
  word_t id_pc;
  word_t id_a;
  word_t id_b;
  word_t id_imm;
  logic id_wr_reg;
  logic id_rd_mem;
  logic id_wr_mem;
  reg_no_t id_wregno;

  // Execute latch
  logic ex_valid;
  word_t ex_result;
  word_t ex_store_data;
  logic ex_wr_reg;
  logic ex_rd_mem;
  logic ex_wr_mem;
  reg_no_t ex_wregno;

  // Memory latch and register write
  logic mem_wr_reg;
  reg_no_t mem_wregno;
  logic wb_en;
  reg_no_t wb_regno;
  word_t wb_data;

  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  execute_stage u_execute (.*);

  memory_stage u_memory (.*);

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             fe_valid,
  input  cpu_pkg::word_t   fe_pc,
  input  cpu_pkg::word_t   fe_inst,
  input  logic             hold,
  input  logic             redirect,
  input  logic             ex_wr_reg,
  input  cpu_pkg::reg_no_t ex_wregno,
  input  logic             mem_wr_reg,
  input  cpu_pkg::reg_no_t mem_wregno,
  input  logic             wb_en,
  input  cpu_pkg::reg_no_t wb_regno,
  input  cpu_pkg::word_t   wb_data,
  output logic             stall,
  output logic             id_valid,
  output cpu_pkg::op1_e    id_op1,
  output cpu_pkg::op2_e    id_op2,
  output cpu_pkg::word_t   id_pc,
  output cpu_pkg::word_t   id_a,
  output cpu_pkg::word_t   id_b,
  output cpu_pkg::word_t   id_imm,
  output logic             id_wr_reg,
  output logic             id_rd_mem,
  output logic             id_wr_mem,
  output cpu_pkg::reg_no_t id_wregno
);
  import cpu_pkg::*;

  op1_e op1;
  op2_e op2;
  logic [IMM_W-1:0] imm;
  reg_no_t rd;
  reg_no_t rs;
  reg_no_t rt;
  word_t regs [REG_WORDS];
  word_t a_val;
  word_t b_val;
  word_t imm_sxt;
  logic wr_reg;
  logic use_rt;
  reg_no_t wregno;
  logic take;

  // True when a pending write lands on a source we read
  function automatic logic dest_hit(input logic wr, input reg_no_t dst,
                                    input reg_no_t src_s, input reg_no_t src_t,
                                    input logic t_used);
    return wr && (dst == src_s || (t_used && dst == src_t));
  endfunction

  // ********************
  // Field split
  // ********************
  assign op1 = op1_e'(fe_inst[31:26]);
  assign op2 = op2_e'(fe_inst[25:18]);
  // Immediate overlaps op2 and rd
  assign imm = fe_inst[23:8];
  assign rd = fe_inst[11:8];
  assign rs = fe_inst[7:4];
  assign rt = fe_inst[3:0];
  assign imm_sxt = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

  // Register reads, new value wins on a same-cycle write
  assign a_val = (wb_en && wb_regno == rs) ? wb_data : regs[rs];
  assign b_val = (wb_en && wb_regno == rt) ? wb_data : regs[rt];

  // Destination and rt usage per opcode, rs is always a source
  always_comb begin
    wr_reg = 1'b0;
    use_rt = 1'b0;
    wregno = rt;
    case (op1)
      OP1_ALUR: begin
        wr_reg = 1'b1;
        use_rt = 1'b1;
        wregno = rd;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI, OP1_LW, OP1_JAL: wr_reg = 1'b1;
      OP1_SW, OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: use_rt = 1'b1;
      default: ;
    endcase
  end

  // Wait on producers in execute, memory and writeback
  assign stall = fe_valid &&
                 (dest_hit(id_wr_reg, id_wregno, rs, rt, use_rt) ||
                  dest_hit(ex_wr_reg, ex_wregno, rs, rt, use_rt) ||
                  dest_hit(mem_wr_reg, mem_wregno, rs, rt, use_rt));

  // Bubble on flush or stall
  assign take = fe_valid && !redirect && !stall;

  // Register file, written back from memory stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_regno] <= wb_data;
    end
  end

  // ********************
  // Decode latch
  // ********************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_wr_reg <= 1'b0;
      id_rd_mem <= 1'b0;
      id_wr_mem <= 1'b0;
      id_wregno <= '0;
    end else if (!hold) begin
      id_valid <= take;
      id_wr_reg <= take && wr_reg;
      id_rd_mem <= take && (op1 == OP1_LW);
      id_wr_mem <= take && (op1 == OP1_SW);
      id_wregno <= wregno;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      id_op1 <= op1;
      id_op2 <= op2;
      id_pc <= fe_pc;
      id_a <= a_val;
      id_b <= b_val;
      id_imm <= imm_sxt;
    end
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             hold,
  input  logic             id_valid,
  input  cpu_pkg::op1_e    id_op1,
  input  cpu_pkg::op2_e    id_op2,
  input  cpu_pkg::word_t   id_pc,
  input  cpu_pkg::word_t   id_a,
  input  cpu_pkg::word_t   id_b,
  input  cpu_pkg::word_t   id_imm,
  input  logic             id_wr_reg,
  input  logic             id_rd_mem,
  input  logic             id_wr_mem,
  input  cpu_pkg::reg_no_t id_wregno,
  output logic             redirect,
  output cpu_pkg::word_t   redirect_pc,
  output logic             ex_valid,
  output cpu_pkg::word_t   ex_result,
  output cpu_pkg::word_t   ex_store_data,
  output logic             ex_wr_reg,
  output logic             ex_rd_mem,
  output logic             ex_wr_mem,
  output cpu_pkg::reg_no_t ex_wregno
);
  import cpu_pkg::*;

  logic signed [DATA_W-1:0] sa;
  logic signed [DATA_W-1:0] sb;
  logic [SHAMT_W-1:0] shamt;
  word_t pc_plus4;
  word_t imm4;
  word_t target;
  word_t alu_out;
  logic taken;
  logic live;

  assign sa = id_a;
  assign sb = id_b;
  assign shamt = id_b[SHAMT_W-1:0];
  assign pc_plus4 = id_pc + INST_BYTES;
  assign imm4 = id_imm << 2;
  // JAL jumps off rs, branches off the next address
  assign target = (id_op1 == OP1_JAL) ? id_a + imm4 : pc_plus4 + imm4;

  // ********************
  // ALU and branch test
  // ********************
  always_comb begin
    alu_out = '0;
    taken = 1'b0;
    case (id_op1)
      OP1_ALUR: begin
        case (id_op2)
          OP2_EQ:   alu_out = word_t'(sa == sb);
          OP2_LT:   alu_out = word_t'(sa < sb);
          OP2_LE:   alu_out = word_t'(sa <= sb);
          OP2_NE:   alu_out = word_t'(sa != sb);
          OP2_ADD:  alu_out = id_a + id_b;
          OP2_AND:  alu_out = id_a & id_b;
          OP2_OR:   alu_out = id_a | id_b;
          OP2_XOR:  alu_out = id_a ^ id_b;
          OP2_SUB:  alu_out = id_a - id_b;
          OP2_NAND: alu_out = ~(id_a & id_b);
          OP2_NOR:  alu_out = ~(id_a | id_b);
          OP2_NXOR: alu_out = ~(id_a ^ id_b);
          OP2_RSHF: alu_out = word_t'(sa >>> shamt);  // sign fill
          OP2_LSHF: alu_out = id_a << shamt;
          default:  alu_out = '0;
        endcase
      end
      // Address generation shares the adder with ADDI
      OP1_ADDI, OP1_LW, OP1_SW: alu_out = id_a + id_imm;
      OP1_ANDI: alu_out = id_a & id_imm;
      OP1_ORI:  alu_out = id_a | id_imm;
      OP1_XORI: alu_out = id_a ^ id_imm;
      OP1_BEQ:  taken = (sa == sb);
      OP1_BLT:  taken = (sa < sb);
      OP1_BLE:  taken = (sa <= sb);
      OP1_BNE:  taken = (sa != sb);
      OP1_JAL: begin
        // Link value
        alu_out = pc_plus4;
        taken = 1'b1;
      end
      default: ;
    endcase
  end

  // Instruction behind a redirect is wrong path
  assign live = id_valid && !redirect;

  // Execute latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect <= 1'b0;
      ex_valid <= 1'b0;
      ex_wr_reg <= 1'b0;
      ex_rd_mem <= 1'b0;
      ex_wr_mem <= 1'b0;
      ex_wregno <= '0;
    end else if (!hold) begin
      redirect <= live && taken;
      ex_valid <= live;
      ex_wr_reg <= live && id_wr_reg;
      ex_rd_mem <= live && id_rd_mem;
      ex_wr_mem <= live && id_wr_mem;
      ex_wregno <= id_wregno;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      redirect_pc <= target;
      ex_result <= alu_out;
      ex_store_data <= id_b;
    end
  end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                prog_valid,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::word_t      prog_word,
  input  logic                hold,
  input  logic                stall,
  input  logic                redirect,
  input  cpu_pkg::word_t      redirect_pc,
  output logic                fe_valid,
  output cpu_pkg::word_t      fe_pc,
  output cpu_pkg::word_t      fe_inst
);
  import cpu_pkg::*;

  word_t imem [IMEM_WORDS];
  word_t pc;
  word_t inst;

  // Program load, one word per valid cycle
  always_ff @(posedge clk) begin
    if (prog_valid) begin
      imem[prog_addr] <= prog_word;
    end
  end

  // Asynchronous read at the current counter
  assign inst = imem[pc[IMEM_MSB:MEM_LSB]];

  // ********************
  // Counter and valid
  // ********************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= START_PC;
      fe_valid <= 1'b0;
    end else if (redirect) begin
      // Taken branch or JAL wins over everything
      pc <= redirect_pc;
      fe_valid <= 1'b0;
    end else if (!(hold || stall)) begin
      if (!start) begin
        pc <= START_PC;
        fe_valid <= 1'b0;
      end else begin
        pc <= pc + INST_BYTES;
        fe_valid <= 1'b1;
      end
    end
  end

  // Word and its address, kept while the pipe waits
  always_ff @(posedge clk) begin
    if (!(hold || stall)) begin
      fe_pc <= pc;
      fe_inst <= inst;
    end
  end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             ex_valid,
  input  cpu_pkg::word_t   ex_result,
  input  cpu_pkg::word_t   ex_store_data,
  input  logic             ex_wr_reg,
  input  logic             ex_rd_mem,
  input  logic             ex_wr_mem,
  input  cpu_pkg::reg_no_t ex_wregno,
  output logic             hold,
  output logic             st_valid,
  output cpu_pkg::word_t   st_addr,
  output cpu_pkg::word_t   st_data,
  input  logic             st_ready,
  output logic             mem_wr_reg,
  output cpu_pkg::reg_no_t mem_wregno,
  output logic             wb_en,
  output cpu_pkg::reg_no_t wb_regno,
  output cpu_pkg::word_t   wb_data
);
  import cpu_pkg::*;

  word_t dmem [DMEM_WORDS];
  word_t load_val;
  logic st_fire;

  // ********************
  // Store port
  // ********************
  // Address and data come straight from the execute latch, so they
  // stay put while the latch is frozen
  assign st_valid = ex_valid && ex_wr_mem;
  assign st_addr = ex_result;
  assign st_data = ex_store_data;
  assign st_fire = st_valid && st_ready;
  // A waiting store freezes every latch
  assign hold = st_valid && !st_ready;

  // Memory write lands on the accepting edge
  always_ff @(posedge clk) begin
    if (st_fire) begin
      dmem[ex_result[DMEM_MSB:MEM_LSB]] <= ex_store_data;
    end
  end

  assign load_val = dmem[ex_result[DMEM_MSB:MEM_LSB]];

  // Memory latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_wr_reg <= 1'b0;
      mem_wregno <= '0;
    end else if (!hold) begin
      mem_wr_reg <= ex_valid && ex_wr_reg;
      mem_wregno <= ex_wregno;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      wb_data <= ex_rd_mem ? load_val : ex_result;
    end
  end

  // Writeback fires once, on the edge where the latch moves on
  assign wb_en = mem_wr_reg && !hold;
  assign wb_regno = mem_wregno;

endmodule

// ==== sources.f ====
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  // Room for all cases in the data file
  localparam int CASE_WORDS = 256;
  // Cycle limits for each kind of wait
  localparam int STORE_TIMEOUT = 2000;
  localparam int DRAIN_CYCLES = 60;
  localparam int IDLE_CYCLES = 10;
  // Word index of the first fetch address
  localparam imem_addr_t START_INDEX = imem_addr_t'(START_PC >> 2);

  logic clk;
  logic reset;
  logic start;
  logic prog_valid;
  imem_addr_t prog_addr;
  word_t prog_word;
  logic st_valid;
  word_t st_addr;
  word_t st_data;
  logic st_ready;

  word_t case_mem [CASE_WORDS];
  word_t lcg_state;
  int check_errors;
  int timeout_errors;
  int case_count;

  cpu_top DUT (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .prog_valid (prog_valid),
    .prog_addr  (prog_addr),
    .prog_word  (prog_word),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .st_ready   (st_ready)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // ********************
  // Back-pressure
  // ********************
  function automatic word_t lcg_next(input word_t state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // One random bit per cycle decides the ready level
  always @(posedge clk) begin
    lcg_state <= lcg_next(lcg_state);
    st_ready <= lcg_state[16];
  end

  // ********************
  // Compare tasks
  // ********************
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      check_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // Reset held for two cycles, start and load port quiet
  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    start <= 1'b0;
    prog_valid <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  // One program word per cycle from the start address on
  task automatic load_program(input int first, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      prog_valid <= 1'b1;
      prog_addr <= START_INDEX + imem_addr_t'(i);
      prog_word <= case_mem[first + i];
    end
    @(posedge clk);
    prog_valid <= 1'b0;
  endtask

  // Nothing may leave the core while start is low
  task automatic check_idle(input int case_no);
    int busy;
    busy = 0;
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      if (st_valid) begin
        busy++;
      end
    end
    check_count($sformatf("case %0d st_valid before start", case_no), busy, 0);
  endtask

  // Next accepted store, sampled on the edge
  // A waiting store must keep its address and data
  task automatic wait_store(output logic seen, output word_t addr, output word_t data);
    int cycles;
    logic waiting;
    word_t held_addr;
    word_t held_data;
    seen = 1'b0;
    waiting = 1'b0;
    cycles = 0;
    while (!seen && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      if (waiting && st_valid) begin
        check_word("st_addr while waiting", st_addr, held_addr);
        check_word("st_data while waiting", st_data, held_data);
      end
      if (st_valid && st_ready) begin
        seen = 1'b1;
        addr = st_addr;
        data = st_data;
      end
      waiting = st_valid && !st_ready;
      held_addr = st_addr;
      held_data = st_data;
      cycles++;
    end
  endtask

  // ********************
  // One case
  // ********************
  task automatic run_case(input int base, input int case_no, output int next);
    int n_prog;
    int n_st;
    int pairs;
    int got;
    int i;
    logic seen;
    logic lost;
    word_t addr;
    word_t data;
    n_prog = int'(case_mem[base]);
    n_st = int'(case_mem[base + 1]);
    pairs = base + 2 + n_prog;
    lost = 1'b0;
    got = 0;
    apply_reset();
    load_program(base + 2, n_prog);
    check_idle(case_no);
    @(posedge clk);
    start <= 1'b1;
    // Stores in program order
    for (i = 0; i < n_st; i++) begin
      wait_store(seen, addr, data);
      if (!seen) begin
        timeout_errors++;
        lost = 1'b1;
        $display("Case %0d timed out waiting for store %0d of %0d", case_no, i + 1, n_st);
        break;
      end
      got++;
      check_word($sformatf("case %0d st_addr", case_no), addr, case_mem[pairs + 2 * i]);
      check_word($sformatf("case %0d st_data", case_no), data, case_mem[pairs + 2 * i + 1]);
    end
    // Program ends in a self-branch, so any further store is extra
    if (!lost) begin
      repeat (DRAIN_CYCLES) begin
        @(posedge clk);
        if (st_valid && st_ready) begin
          got++;
        end
      end
      check_count($sformatf("case %0d store count", case_no), got, n_st);
    end
    next = pairs + 2 * n_st;
  endtask

  initial begin
    int ptr;
    int next_ptr;
    int i;
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    prog_valid = 1'b0;
    prog_addr = '0;
    prog_word = '0;
    st_ready = 1'b0;
    lcg_state = 32'd56993;
    check_errors = 0;
    timeout_errors = 0;
    case_count = 0;
    ptr = 0;
    // Unread words stay zero and end the list
    for (i = 0; i < CASE_WORDS; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("cpu_cases.txt", case_mem);
    while (ptr < CASE_WORDS - 2 && case_mem[ptr] != '0) begin
      case_count++;
      run_case(ptr, case_count, next_ptr);
      ptr = next_ptr;
    end
    if (case_count == 0) begin
      check_errors++;
      $display("No cases were found in cpu_cases.txt");
    end
    $display("Cases %0d, check errors %0d, timeouts %0d",
             case_count, check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
